//--- Makefile
# Verilator simulation of the multiply unit.

VERILATOR ?= verilator
TOP       ?= tb_mul_unit
FILELIST  ?= mul_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_mul_unit.sv
`include "mul_params.svh"

module tb_mul_unit;
  timeunit 1ns;
  timeprecision 100ps;
  import mul_pkg::*;

  localparam int unsigned W              = `MUL_WIDTH;
  localparam int unsigned DEPTH          = `MUL_FIFO_DEPTH;
  localparam int unsigned SEED           = 22566;
  localparam int unsigned NUM_UNSIGNED   = 5;
  localparam int unsigned NUM_SIGNED     = 4;
  localparam int unsigned NUM_RANDOM     = 20;
  localparam int unsigned NUM_BP         = DEPTH + 4;
  localparam int unsigned NUM_REQS       = NUM_UNSIGNED + NUM_SIGNED + NUM_RANDOM + NUM_BP;
  localparam int unsigned TIMEOUT_FACTOR = 10;
  localparam int unsigned CLK_PERIOD     = 8;
  localparam int unsigned HOLD_CYCLES    = 20;
  localparam longint unsigned TIMEOUT_NS = NUM_REQS * (W + TIMEOUT_FACTOR) * CLK_PERIOD;

  localparam logic [W-1:0] ALL_ONES = {W{1'b1}};
  localparam logic [W-1:0] HIGH_BIT = {1'b1, {(W-1){1'b0}}};  // also the most negative value.

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  req_valid_i;
  logic                  req_ready_o;
  mul_req_t              req_i;
  logic                  res_valid_o;
  logic                  res_ready_i;
  mul_res_t              res_o;

  integer                seed;
  logic [`MUL_TAG_W-1:0] next_tag;
  mul_res_t              exp_q[$];  // expected results in request order.

  mul_unit i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // error handling
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at %0t: %s", $time, what);
    stop_run();
  endtask

  task automatic check_value(input string name, input logic [2*W-1:0] expected,
                             input logic [2*W-1:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
      stop_run();
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("ERROR at %0t: timeout, the DUT did not finish the requests in time", $time);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic push_expected(input mul_req_t req);
    logic [2*W-1:0] wide_a;
    logic [2*W-1:0] wide_b;
    mul_res_t       res;
    if (req.is_signed) begin
      wide_a = {{W{req.operand_a[W-1]}}, req.operand_a};  // sign extended.
      wide_b = {{W{req.operand_b[W-1]}}, req.operand_b};
    end else begin
      wide_a = {{W{1'b0}}, req.operand_a};
      wide_b = {{W{1'b0}}, req.operand_b};
    end
    res.product = wide_a * wide_b;  // low 2W bits hold the full product.
    res.tag     = req.tag;
    exp_q.push_back(res);
  endtask

  // the transfer happens on the next rising edge.
  always @(negedge clk_i) begin
    mul_res_t exp_res;
    if (rst_ni && res_valid_o && res_ready_i) begin
      if (exp_q.size() == 0) begin
        report_failure("a result came out with no request outstanding");
      end
      exp_res = exp_q.pop_front();
      check_value("res_o.tag", exp_res.tag, res_o.tag);
      check_value("res_o.product", exp_res.product, res_o.product);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request driving
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic build_req(input logic [W-1:0] a, input logic [W-1:0] b, input logic sgn,
                           output mul_req_t req);
    req.operand_a = a;
    req.operand_b = b;
    req.is_signed = sgn;
    req.tag       = next_tag;
    next_tag      = next_tag + 1'b1;
  endtask

  task automatic build_random_req(output mul_req_t req);
    logic [31:0] rnd;
    logic [W-1:0] a;
    logic [W-1:0] b;
    rnd = $random(seed);
    a   = W'({$random(seed), $random(seed)});
    b   = W'({$random(seed), $random(seed)});
    build_req(a, b, rnd[0], req);
  endtask

  // called with valid already raised; returns on the transfer edge.
  task automatic wait_accept(input mul_req_t req);
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    push_expected(req);
  endtask

  task automatic send_req(input logic [W-1:0] a, input logic [W-1:0] b, input logic sgn);
    mul_req_t req;
    build_req(a, b, sgn, req);
    req_valid_i <= 1'b1;
    req_i       <= req;
    wait_accept(req);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk_i);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic reset_state_test();
    @(negedge clk_i);
    check_value("res_valid_o", 1'b0, res_valid_o);
    check_value("req_ready_o", 1'b1, req_ready_o);
    @(posedge clk_i);
  endtask

  task automatic unsigned_corner_test();
    res_ready_i <= 1'b1;
    send_req('0, ALL_ONES, 1'b0);
    send_req(W'(1), W'(64'h1234_5678_9abc_def0), 1'b0);
    send_req(ALL_ONES, ALL_ONES, 1'b0);
    send_req(HIGH_BIT, HIGH_BIT, 1'b0);
    send_req(HIGH_BIT, W'(2), 1'b0);  // carries into the upper half.
    req_valid_i <= 1'b0;
    wait_drain();
  endtask

  task automatic signed_corner_test();
    res_ready_i <= 1'b1;
    send_req(W'(-5), W'(7), 1'b1);
    send_req(W'(-3), W'(-9), 1'b1);
    send_req(HIGH_BIT, HIGH_BIT, 1'b1);
    send_req(HIGH_BIT, W'(1), 1'b1);
    req_valid_i <= 1'b0;
    wait_drain();
  endtask

  task automatic random_stream_test();
    mul_req_t req;
    res_ready_i <= 1'b1;
    repeat (NUM_RANDOM) begin
      build_random_req(req);
      req_valid_i <= 1'b1;
      req_i       <= req;
      wait_accept(req);
    end
    req_valid_i <= 1'b0;
    wait_drain();
  endtask

  task automatic backpressure_test();
    mul_req_t    req;
    mul_res_t    held;
    int unsigned accepted;
    logic        stalled;
    accepted = 0;
    stalled  = 1'b0;
    res_ready_i <= 1'b0;
    while (!stalled && accepted < NUM_BP) begin
      build_random_req(req);
      req_valid_i <= 1'b1;
      req_i       <= req;
      @(negedge clk_i);
      if (!req_ready_o) begin
        stalled = 1'b1;  // req stays offered.
      end else begin
        @(posedge clk_i);
        push_expected(req);
        accepted++;
      end
    end
    if (!stalled) begin
      report_failure("req_ready_o stayed high while results were blocked");
    end
    if (accepted > DEPTH + 2) begin
      report_failure("more requests were accepted than the pipeline can hold");
    end
    while (!res_valid_o) @(negedge clk_i);
    held = res_o;
    repeat (HOLD_CYCLES) begin
      @(negedge clk_i);
      check_value("res_valid_o", 1'b1, res_valid_o);
      check_value("res_o.product", held.product, res_o.product);
      check_value("res_o.tag", held.tag, res_o.tag);
      check_value("req_ready_o", 1'b0, req_ready_o);
    end
    @(posedge clk_i);
    res_ready_i <= 1'b1;
    wait_accept(req);
    accepted++;
    while (accepted < NUM_BP) begin
      build_random_req(req);
      req_valid_i <= 1'b1;
      req_i       <= req;
      wait_accept(req);
      accepted++;
    end
    req_valid_i <= 1'b0;
    wait_drain();
  endtask

  initial begin
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    res_ready_i = 1'b0;
    seed        = SEED;
    next_tag    = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    reset_state_test();
    unsigned_corner_test();
    signed_corner_test();
    random_stream_test();
    backpressure_test();
    $display("all tests passed");
    $finish;
  end

endmodule : tb_mul_unit

//--- design/mul_operand_prep.sv
`include "mul_params.svh"

module mul_operand_prep (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  mul_pkg::mul_req_t   in_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output mul_pkg::mul_prep_t  out_o
);
  import mul_pkg::*;

  localparam int unsigned W = `MUL_WIDTH;

  logic      sign_a;
  logic      sign_b;
  logic      valid_q;
  mul_prep_t prep_d;
  mul_prep_t prep_q;

  assign sign_a = in_i.is_signed & in_i.operand_a[W-1];
  assign sign_b = in_i.is_signed & in_i.operand_b[W-1];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // magnitude conversion
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    prep_d.mag_a  = sign_a ? (~in_i.operand_a + 1'b1) : in_i.operand_a;
    prep_d.mag_b  = sign_b ? (~in_i.operand_b + 1'b1) : in_i.operand_b;
    prep_d.negate = sign_a ^ sign_b;  // clear in unsigned mode.
    prep_d.tag    = in_i.tag;
  end

  // empty stage, or the held item leaves this cycle.
  assign in_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      prep_q <= prep_d;
    end
  end

  assign out_valid_o = valid_q;
  assign out_o       = prep_q;

endmodule : mul_operand_prep

//--- design/mul_pkg.sv
`include "mul_params.svh"

package mul_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request and result types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [`MUL_WIDTH-1:0] operand_a;
    logic [`MUL_WIDTH-1:0] operand_b;
    logic                  is_signed;  // both operands two's complement.
    logic [`MUL_TAG_W-1:0] tag;
  } mul_req_t;

  typedef struct packed {
    logic [`MUL_WIDTH-1:0] mag_a;
    logic [`MUL_WIDTH-1:0] mag_b;
    logic                  negate;     // sign of the product.
    logic [`MUL_TAG_W-1:0] tag;
  } mul_prep_t;

  typedef struct packed {
    logic [2*`MUL_WIDTH-1:0] product;
    logic [`MUL_TAG_W-1:0]   tag;
  } mul_res_t;

endpackage : mul_pkg

//--- design/mul_req_fifo.sv
`include "mul_params.svh"

module mul_req_fifo (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                wr_valid_i,
  output logic                wr_ready_o,
  input  mul_pkg::mul_prep_t  wr_i,
  output logic                rd_valid_o,
  input  logic                rd_ready_i,
  output mul_pkg::mul_prep_t  rd_o
);
  import mul_pkg::*;

  localparam int unsigned DEPTH = `MUL_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  mul_prep_t        mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             wr_fire;
  logic             rd_fire;

  assign wr_ready_o = (count_q != CNT_W'(DEPTH));  // low only when full.
  assign rd_valid_o = (count_q != '0);
  assign rd_o       = mem_q[rd_ptr_q];

  assign wr_fire = wr_valid_i && wr_ready_o;
  assign rd_fire = rd_valid_o && rd_ready_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers and fill count
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth.
      end
      if (rd_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (wr_fire && !rd_fire) begin
        count_q <= count_q + 1'b1;
      end else if (rd_fire && !wr_fire) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      mem_q[wr_ptr_q] <= wr_i;
    end
  end

  a_count_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CNT_W'(DEPTH));

  // an empty fifo can only stay empty or gain one entry.
  a_count_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (count_q == '0) |=> (count_q <= CNT_W'(1)));

endmodule : mul_req_fifo

//--- design/mul_shift_add.sv
`include "mul_params.svh"

module mul_shift_add (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  mul_pkg::mul_prep_t  in_i,
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output mul_pkg::mul_res_t   res_o
);
  import mul_pkg::*;

  localparam int unsigned W     = `MUL_WIDTH;
  localparam int unsigned IDX_W = $clog2(W);

  typedef enum logic [1:0] {
    IDLE,
    MUL,
    SIGN,
    DONE
  } state_e;

  state_e           state_q;
  state_e           state_d;
  mul_prep_t        item_q;
  logic [IDX_W-1:0] idx_q;
  logic [2*W-1:0]   acc_q;
  logic [2*W-1:0]   addend;
  logic             last_bit;
  logic             accept;

  assign in_ready_o  = (state_q == IDLE);
  assign accept      = in_valid_i && in_ready_o;
  assign last_bit    = (idx_q == IDX_W'(W - 1));
  assign addend      = {{W{1'b0}}, item_q.mag_a} << idx_q;
  assign res_valid_o = (state_q == DONE);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control fsm
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = MUL;
        end
      end
      MUL: begin
        if (last_bit) begin
          state_d = SIGN;
        end
      end
      SIGN: begin
        state_d = DONE;
      end
      DONE: begin
        if (res_ready_i) begin
          state_d = IDLE;  // free again next cycle.
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        idx_q <= '0;
      end else if (state_q == MUL) begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (accept) begin
      item_q <= in_i;
      acc_q  <= '0;
    end else if (state_q == MUL) begin
      if (item_q.mag_b[idx_q]) begin
        acc_q <= acc_q + addend;  // one multiplier bit per clock.
      end
    end else if (state_q == SIGN) begin
      if (item_q.negate) begin
        acc_q <= ~acc_q + 1'b1;
      end
    end
  end

  assign res_o.product = acc_q;
  assign res_o.tag     = item_q.tag;

  a_res_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o)));

endmodule : mul_shift_add

//--- design/mul_unit.sv
module mul_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  mul_pkg::mul_req_t  req_i,
  output logic               res_valid_o,
  input  logic               res_ready_i,
  output mul_pkg::mul_res_t  res_o
);
  import mul_pkg::*;

  logic      prep_valid;
  logic      prep_ready;
  mul_prep_t prep;
  logic      fifo_valid;
  logic      fifo_ready;
  mul_prep_t fifo_data;

  mul_operand_prep i_prep (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .in_i        (req_i),
    .out_valid_o (prep_valid),
    .out_ready_i (prep_ready),
    .out_o       (prep)
  );

  mul_req_fifo i_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_valid_i (prep_valid),
    .wr_ready_o (prep_ready),
    .wr_i       (prep),
    .rd_valid_o (fifo_valid),
    .rd_ready_i (fifo_ready),
    .rd_o       (fifo_data)
  );

  mul_shift_add i_core (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (fifo_valid),
    .in_ready_o  (fifo_ready),
    .in_i        (fifo_data),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res_o)
  );

endmodule : mul_unit

//--- include/mul_params.svh
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multiply unit sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define MUL_WIDTH       64  // operand width in bits.
`define MUL_FIFO_DEPTH  4   // power of two request fifo entries.
`define MUL_TAG_W       4   // request tag width.

`endif

//--- mul_unit.f
+incdir+include
design/mul_pkg.sv
design/mul_operand_prep.sv
design/mul_req_fifo.sv
design/mul_shift_add.sv
design/mul_unit.sv
bench/tb_mul_unit.sv
